//--- host_decode.sv
`include "tgen_settings.svh"

module host_decode import tgen_pkg::*; (
	input logic clk,
	input logic rst,
	input lb_bus_t host_bus,
	output table_wr_t table_wr,
	output lb_bus_t thru_bus,
	output logic bank_next
);

	localparam logic [`TGEN_AW-1:0] table_base = `TGEN_TABLE_BASE;
	localparam logic [`TGEN_AW-1:0] ctrl_addr = `TGEN_CTRL_ADDR;

	// Address class of the current beat
	logic in_table;
	logic is_ctrl;

	// Window check only looks at the bits above the word offset
	assign in_table = host_bus.addr[`TGEN_AW-1:`TGEN_PCW] ==
		table_base[`TGEN_AW-1:`TGEN_PCW];
	assign is_ctrl = host_bus.addr == ctrl_addr;

	// Table port
	// Only the low half-word goes into the memory
	always_comb begin
		table_wr.write = host_bus.write && in_table;
		table_wr.addr = host_bus.addr[`TGEN_PCW-1:0];
		table_wr.data = host_bus.data[15:0];
	end

	// Everything else goes straight on to the merger
	always_comb begin
		thru_bus = host_bus;
		thru_bus.write = host_bus.write && !in_table && !is_ctrl;
	end

	// Requested bank for the next trigger
	// Takes effect only when the sequencer starts a run
	always_ff @(posedge clk) begin
		if (rst) begin
			bank_next <= 1'b0;
		end else if (host_bus.write && is_ctrl) begin
			bank_next <= host_bus.data[0];
		end
	end

	// Each host beat lands in exactly one place
	a_one_dest: assert property (@(posedge clk) disable iff (rst)
		!(table_wr.write && thru_bus.write));

endmodule

//--- program_ram.sv
`include "tgen_settings.svh"

module program_ram import tgen_pkg::*; (
	input logic clk,
	input table_wr_t table_wr,
	input logic wr_bank,
	input logic [`TGEN_PCW:0] rd_addr,
	output logic [15:0] rd_data
);

	// Two banks of 2**PCW half-words
	localparam int depth = 2 * (2 ** `TGEN_PCW);

	logic [15:0] mem [depth];

	// Host side write address
	// Bank bit on top, word offset below
	logic [`TGEN_PCW:0] wr_addr;

	assign wr_addr = {wr_bank, table_wr.addr};

	// Host write port
	always_ff @(posedge clk) begin
		if (table_wr.write) begin
			mem[wr_addr] <= table_wr.data;
		end
	end

	// Sequencer read port
	// Data appears one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

	// Both ports share a clock
	// A read of the word being written returns the old contents
	// The sequencer never reads the host bank, so it never matters

endmodule

//--- program_sequencer.sv
`include "tgen_settings.svh"

module program_sequencer import tgen_pkg::*; (
	input logic clk,
	input logic rst,
	input logic trig,
	input logic bank_next,
	output logic [`TGEN_PCW:0] rd_addr,
	input logic [15:0] rd_data,
	output lb_bus_t seq_bus,
	output tgen_status_t status
);

	// Timer holds a shifted 16-bit delay
	localparam int tw = 16 + `TGEN_GRAN;

	logic [`TGEN_PCW-1:0] pc;
	logic [1:0] subcycle;
	logic [tw-1:0] timer;

	// Run control
	logic start;
	logic start_d;
	logic advance;
	logic end_prog;

	// Bank and history
	logic bank;
	logic bank_prev;
	logic work_prev;
	logic did_work;

	// Read data pipeline
	logic [15:0] word_d1;
	logic [15:0] word_d2;
	logic addr_zero;
	logic write_cycle;

	assign subcycle = pc[1:0];

	// Trigger counts only when idle
	// start_d blocks a held trigger from flipping the banks twice
	assign start = trig && pc == '0 && !start_d;

	// Idle: step off zero one cycle after the trigger
	// Running: subcycles 1 to 3 always step, subcycle 0 waits for the timer
	assign advance = (pc == '0) ? start_d : (subcycle != 2'd0 || timer == '0);

	// Zero target address seen in the entry's last subcycle
	assign end_prog = subcycle == 2'd3 && addr_zero;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			timer <= '0;
			start_d <= 1'b0;
		end else begin
			start_d <= start;
			if (end_prog) begin
				pc <= '0;
			end else if (advance) begin
				pc <= pc + 1'b1;
			end
			// Delay word arrives while pc sits at subcycle 1
			if (subcycle == 2'd1) begin
				timer <= tw'(rd_data) << `TGEN_GRAN;
			end else if (subcycle == 2'd0 && timer != '0) begin
				timer <= timer - 1'b1;
			end
		end
	end

	// Atomic bank flip at the start of a run
	always_ff @(posedge clk) begin
		if (rst) begin
			bank <= 1'b0;
			bank_prev <= 1'b0;
			work_prev <= 1'b0;
		end else if (start) begin
			bank <= bank_next;
			bank_prev <= bank;
			work_prev <= did_work;
		end
	end

	// Set by the first write of a run
	always_ff @(posedge clk) begin
		if (rst) begin
			did_work <= 1'b0;
		end else if (start) begin
			did_work <= 1'b0;
		end else if (write_cycle) begin
			did_work <= 1'b1;
		end
	end

	// Sequencer reads the bank the host is not writing
	assign rd_addr = {~bank, pc};

	// Delay line lining up address, low and high half-words
	always_ff @(posedge clk) begin
		word_d1 <= rd_data;
		word_d2 <= word_d1;
	end

	// addr_zero looks at the address word, valid in subcycle 3
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_zero <= 1'b0;
			write_cycle <= 1'b0;
		end else begin
			addr_zero <= rd_data == '0;
			write_cycle <= subcycle == 2'd3 && !addr_zero;
		end
	end

	// High half-word is on the read port during the write cycle
	assign seq_bus.write = write_cycle;
	assign seq_bus.addr = {{(`TGEN_AW-16){1'b0}}, word_d2};
	assign seq_bus.data = {rd_data, word_d1};

	assign status.work_prev = work_prev;
	assign status.bank_prev = bank_prev;
	assign status.bank = bank;
	assign status.bank_next = bank_next;

	// Writes only happen inside a run
	a_write_in_run: assert property (@(posedge clk) disable iff (rst)
		seq_bus.write |-> pc != '0);

	// The terminator never reaches the bus
	a_no_zero_addr: assert property (@(posedge clk) disable iff (rst)
		seq_bus.write |-> seq_bus.addr != '0);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and reports pass or fail
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/100ps \
	--top-module tgen_tb \
	-f timing_gen.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtgen_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qF "*** TEST PASSED ***" <<< "$sim_out"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

//--- tgen_pkg.sv
`include "tgen_settings.svh"

package tgen_pkg;

	// One beat of the local write bus
	// write is a single-cycle strobe, no handshake
	typedef struct packed {
		logic write;
		logic [`TGEN_AW-1:0] addr;
		logic [31:0] data;
	} lb_bus_t;

	// One write into the program table
	// Address is the word offset inside one bank
	typedef struct packed {
		logic write;
		logic [`TGEN_PCW-1:0] addr;
		logic [15:0] data;
	} table_wr_t;

	// Monitoring flags, MSB first
	// work_prev: the previous run issued at least one write
	// bank_prev: bank register before the last flip
	// bank: bank the host currently writes into
	// bank_next: value requested through the control register
	typedef struct packed {
		logic work_prev;
		logic bank_prev;
		logic bank;
		logic bank_next;
	} tgen_status_t;

endpackage

//--- tgen_settings.svh
`ifndef TGEN_SETTINGS_SVH
`define TGEN_SETTINGS_SVH

// Local bus address width
// Host and output bus share it
`define TGEN_AW 17

// Program counter width
// Four words per entry, so 256 entries per bank
`define TGEN_PCW 10

// Delay granularity shift
// One delay unit is 2**TGEN_GRAN clock cycles
`define TGEN_GRAN 0

// Register map
// Table window is 2**TGEN_PCW words long, aligned to its size
`define TGEN_TABLE_BASE 17'h10000

// Control register, bit 0 selects the bank for the next trigger
`define TGEN_CTRL_ADDR 17'h00100

// Entry layout inside the table window
//   word 0: delay after the write
//   word 1: target address, zero ends the program
//   word 2: low data half-word
//   word 3: high data half-word

`endif

//--- tgen_tb.sv
`include "tgen_settings.svh"

module tgen_tb import tgen_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// All tests together run a few hundred cycles
	// The limit leaves a wide margin above that
	localparam int max_cycles = 4000;
	// Cycles a run may take to show all of its writes
	localparam int run_limit = 300;
	// Quiet window after a run, longer than any delay used here
	localparam int settle = 40;

	logic clk;
	logic rst;
	logic trig;
	lb_bus_t host_bus;
	lb_bus_t out_bus;
	logic collision;
	logic [7:0] collision_count;
	tgen_status_t status;

	int cyc;
	// Collision pulses seen on the output
	int coll_seen;

	// Every out_bus write with the cycle it was seen in
	lb_bus_t mon_bus[$];
	int mon_cyc[$];

	// Pass-through beats sent by the host and where they should come out
	lb_bus_t exp_bus[$];
	int exp_cyc[$];

	// Current program, terminator not counted
	int prog_len;
	logic [15:0] prog_delay[3];
	logic [15:0] prog_addr[3];
	logic [31:0] prog_data[3];

	// Expected flags, updated by the bank flip rule
	tgen_status_t model;
	logic last_run_work;

	timing_gen_top uut (
		.clk(clk),
		.rst(rst),
		.trig(trig),
		.host_bus(host_bus),
		.out_bus(out_bus),
		.collision(collision),
		.collision_count(collision_count),
		.status(status)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Output is registered
	// The edge still sees the beat of the previous cycle
	always @(posedge clk) begin
		if (out_bus.write) begin
			mon_bus.push_back(out_bus);
			mon_cyc.push_back(cyc);
		end
		if (collision) begin
			coll_seen++;
		end
		cyc <= cyc + 1;
		if (cyc >= max_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", max_cycles);
			$display("*** TEST FAILED ***");
			$fatal(1, "timeout");
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "%s", msg);
	endtask

	task automatic check_bus(input string name, input lb_bus_t exp, input lb_bus_t act);
		if (act !== exp) begin
			abort_run($sformatf("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act));
		end
	endtask

	task automatic check_status(input string name, input tgen_status_t exp,
		input tgen_status_t act);
		if (act !== exp) begin
			abort_run($sformatf("Error at %0d ns: %s expected %b, got %b", $time, name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			abort_run($sformatf("Error at %0d ns: %s expected %0d, got %0d",
				$time, name, exp, act));
		end
	endtask

	// Integer results such as cycle numbers, spacings and pulse counts
	task automatic check_cycle(input string name, input int exp, input int act);
		if (act != exp) begin
			abort_run($sformatf("Error at %0d ns: %s expected %0d, got %0d",
				$time, name, exp, act));
		end
	endtask

	// Starts on a falling edge and returns on the next one
	task automatic host_write(input logic [`TGEN_AW-1:0] addr, input logic [31:0] data);
		host_bus.write = 1'b1;
		host_bus.addr = addr;
		host_bus.data = data;
		@(negedge clk);
		host_bus.write = 1'b0;
	endtask

	task automatic pulse_trig();
		trig = 1'b1;
		@(negedge clk);
		trig = 1'b0;
	endtask

	// Random beat below the table window, never the control register
	task automatic pass_beat();
		lb_bus_t beat;
		logic [31:0] r;
		r = $urandom;
		beat.write = 1'b1;
		beat.addr = '0;
		beat.addr[15:0] = r[15:0];
		if (beat.addr == `TGEN_CTRL_ADDR) begin
			beat.addr[0] = ~beat.addr[0];
		end
		beat.data = $urandom;
		exp_bus.push_back(beat);
		exp_cyc.push_back(cyc + 1);
		host_write(beat.addr, beat.data);
	endtask

	// Output must hold exactly the recorded host beats, one cycle late
	task automatic check_pass();
		if (mon_bus.size() != exp_bus.size()) begin
			abort_run($sformatf("Saw %0d output writes, expected %0d pass-through beats",
				mon_bus.size(), exp_bus.size()));
		end
		foreach (exp_bus[i]) begin
			check_bus($sformatf("out_bus[%0d]", i), exp_bus[i], mon_bus[i]);
			check_cycle($sformatf("out_bus[%0d] cycle", i), exp_cyc[i], mon_cyc[i]);
		end
	endtask

	// Three entries with the given delays, random nonzero 16-bit targets
	task automatic make_program(input logic [15:0] d0, input logic [15:0] d1,
		input logic [15:0] d2);
		logic [31:0] r;
		prog_len = 3;
		prog_delay[0] = d0;
		prog_delay[1] = d1;
		prog_delay[2] = d2;
		for (int i = 0; i < 3; i++) begin
			r = $urandom;
			prog_addr[i] = (r[15:0] == 16'h0) ? 16'h1 : r[15:0];
			prog_data[i] = $urandom;
		end
	endtask

	// Entry words are delay, address, low half and high half
	// A zero entry ends the table
	task automatic load_program();
		logic [`TGEN_AW-1:0] waddr;
		logic [15:0] words[4];
		waddr = `TGEN_TABLE_BASE;
		for (int i = 0; i <= prog_len; i++) begin
			if (i < prog_len) begin
				words = '{prog_delay[i], prog_addr[i], prog_data[i][15:0], prog_data[i][31:16]};
			end else begin
				words = '{default: 16'h0};
			end
			for (int k = 0; k < 4; k++) begin
				host_write(waddr, {16'h0, words[k]});
				waddr++;
			end
		end
		// Host fills the current bank, so the next run wants the other one
		model.bank_next = ~model.bank;
		host_write(`TGEN_CTRL_ADDR, {31'h0, model.bank_next});
	endtask

	// Bank flip as seen by the model at a trigger from idle
	task automatic note_trigger();
		model.bank_prev = model.bank;
		model.bank = model.bank_next;
		model.work_prev = last_run_work;
		last_run_work = prog_len > 0;
		mon_bus.delete();
		mon_cyc.delete();
	endtask

	task automatic wait_writes(input int n);
		int waited;
		waited = 0;
		while (mon_bus.size() < n) begin
			if (waited >= run_limit) begin
				abort_run($sformatf("Only %0d of %0d program writes arrived", mon_bus.size(), n));
			end
			@(negedge clk);
			waited++;
		end
	endtask

	// Writes in table order with data high over low
	// Spacing is 4 plus the earlier delay
	task automatic check_run();
		lb_bus_t exp;
		wait_writes(prog_len);
		repeat (settle) @(negedge clk);
		if (mon_bus.size() != prog_len) begin
			abort_run($sformatf("Run gave %0d output writes instead of %0d",
				mon_bus.size(), prog_len));
		end
		for (int i = 0; i < prog_len; i++) begin
			exp.write = 1'b1;
			exp.addr = '0;
			exp.addr[15:0] = prog_addr[i];
			exp.data = prog_data[i];
			check_bus($sformatf("out_bus[%0d]", i), exp, mon_bus[i]);
			if (i > 0) begin
				check_cycle($sformatf("write spacing %0d", i),
					4 + (int'(prog_delay[i - 1]) << `TGEN_GRAN), mon_cyc[i] - mon_cyc[i - 1]);
			end
		end
		check_status("status", model, status);
	endtask

	task automatic test_pass_through();
		mon_bus.delete();
		mon_cyc.delete();
		exp_bus.delete();
		exp_cyc.delete();
		pass_beat();
		// Table word and control register writes stay inside
		host_write(`TGEN_TABLE_BASE + 17'h3ff, $urandom);
		host_write(`TGEN_CTRL_ADDR, 32'h1);
		model.bank_next = 1'b1;
		repeat (4) @(negedge clk);
		check_pass();
		check_status("status", model, status);
		host_write(`TGEN_CTRL_ADDR, 32'h0);
		model.bank_next = 1'b0;
	endtask

	task automatic test_first_run();
		make_program(16'd0, 16'd5, 16'd20);
		load_program();
		note_trigger();
		pulse_trig();
		check_run();
	endtask

	// Second run also covers delay 20 and a trigger in mid-run
	task automatic test_retrigger();
		make_program(16'd20, 16'd2, 16'd9);
		load_program();
		note_trigger();
		pulse_trig();
		wait_writes(1);
		pulse_trig();
		check_run();
	endtask

	// Host busy on every cycle so every program write gets lost
	task automatic test_collisions();
		int base;
		int waited;
		make_program(16'd1, 16'd2, 16'd3);
		load_program();
		base = int'(collision_count);
		note_trigger();
		exp_bus.delete();
		exp_cyc.delete();
		coll_seen = 0;
		trig = 1'b1;
		pass_beat();
		trig = 1'b0;
		waited = 0;
		while (int'(collision_count) < base + prog_len && waited < run_limit) begin
			pass_beat();
			waited++;
		end
		// Stay busy well past the terminator
		repeat (settle) begin
			pass_beat();
		end
		repeat (4) @(negedge clk);
		check_count("collision_count", 8'(base + prog_len), collision_count);
		check_cycle("collision pulses", prog_len, coll_seen);
		check_pass();
		check_status("status", model, status);
	endtask

	initial begin
		rst = 1'b1;
		trig = 1'b0;
		host_bus = '0;
		model = '0;
		last_run_work = 1'b0;
		prog_len = 0;
		void'($urandom(32'h50));
		// Three rising edges with reset high
		repeat (3) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		if (out_bus.write || collision) begin
			abort_run("Output write or collision pulse active right after reset");
		end
		check_count("collision_count", 8'h00, collision_count);
		check_status("status", model, status);
		test_pass_through();
		test_first_run();
		test_retrigger();
		test_collisions();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- timing_gen.f
+incdir+.
tgen_pkg.sv
program_ram.sv
host_decode.sv
program_sequencer.sv
write_merge.sv
timing_gen_top.sv
tgen_tb.sv

//--- timing_gen_top.sv
`include "tgen_settings.svh"

module timing_gen_top import tgen_pkg::*; (
	input logic clk,
	input logic rst,
	input logic trig,
	input lb_bus_t host_bus,
	output lb_bus_t out_bus,
	output logic collision,
	output logic [7:0] collision_count,
	output tgen_status_t status
);

	// Decoder outputs
	table_wr_t table_wr;
	lb_bus_t thru_bus;
	logic bank_next;

	// Sequencer side
	logic [`TGEN_PCW:0] rd_addr;
	logic [15:0] rd_data;
	lb_bus_t seq_bus;

	host_decode u_decode (
		.clk(clk),
		.rst(rst),
		.host_bus(host_bus),
		.table_wr(table_wr),
		.thru_bus(thru_bus),
		.bank_next(bank_next)
	);

	program_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.trig(trig),
		.bank_next(bank_next),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.seq_bus(seq_bus),
		.status(status)
	);

	// Host fills the bank that is not running
	program_ram u_ram (
		.clk(clk),
		.table_wr(table_wr),
		.wr_bank(status.bank),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	write_merge u_merge (
		.clk(clk),
		.rst(rst),
		.thru_bus(thru_bus),
		.seq_bus(seq_bus),
		.out_bus(out_bus),
		.collision(collision),
		.collision_count(collision_count)
	);

endmodule

//--- write_merge.sv
`include "tgen_settings.svh"

module write_merge import tgen_pkg::*; (
	input logic clk,
	input logic rst,
	input lb_bus_t thru_bus,
	input lb_bus_t seq_bus,
	output lb_bus_t out_bus,
	output logic collision,
	output logic [7:0] collision_count
);

	// Winning beat, host first
	lb_bus_t win;

	// Registered output payload
	logic [`TGEN_AW-1:0] out_addr;
	logic [31:0] out_data;
	logic out_write;

	assign win = thru_bus.write ? thru_bus : seq_bus;

	// Payload just follows the winner
	always_ff @(posedge clk) begin
		out_addr <= win.addr;
		out_data <= win.data;
	end

	// Strobe and collision pulse
	// A lost sequencer beat is dropped, never retried
	always_ff @(posedge clk) begin
		if (rst) begin
			out_write <= 1'b0;
			collision <= 1'b0;
		end else begin
			out_write <= thru_bus.write || seq_bus.write;
			collision <= thru_bus.write && seq_bus.write;
		end
	end

	// Counts registered pulses, stops at 255
	always_ff @(posedge clk) begin
		if (rst) begin
			collision_count <= '0;
		end else if (collision && collision_count != 8'hff) begin
			collision_count <= collision_count + 1'b1;
		end
	end

	assign out_bus.write = out_write;
	assign out_bus.addr = out_addr;
	assign out_bus.data = out_data;

	// On a collision the host beat is the one that came out
	a_host_wins: assert property (@(posedge clk) disable iff (rst)
		collision |-> out_bus == $past(thru_bus));

endmodule
